//--- hw/axil_slave_pkg.sv
`default_nettype none

package axil_slave_pkg;

  // AXI response codes
  // EXOKAY (2'b01) has no meaning for AXI-lite and is left out
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // width of one probability input and of one random byte
  // 0 never misbehaves, 255 misbehaves almost always
  localparam int PROB_W = 8;

  // generator state, eight random bytes per cycle
  localparam int PRNG_W = 64;

  // fixed seed so that every run repeats
  // must be nonzero, xorshift stays stuck at zero
  localparam logic [PRNG_W-1:0] PRNG_SEED = 64'h243f_6a88_85a3_08d3;

endpackage

`default_nettype wire

//--- hw/fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

// joins one payload queue to its producer and consumer
interface fifo_if #(
  parameter type T = logic
);

  logic push;   // write one entry
  logic pop;    // drop the head entry
  T     wdata;
  T     rdata;  // head entry
  logic empty;
  logic full;

  modport queue (input push, pop, wdata, output rdata, empty, full);

  modport producer (output push, wdata, input full);

  modport consumer (output pop, input rdata, empty);

endinterface

`default_nettype wire

//--- hw/prng_xorshift.sv
`timescale 1ns/1ps
`default_nettype none

module prng_xorshift (
  input  logic                              i_clk,
  input  logic                              i_rst,
  output logic [axil_slave_pkg::PRNG_W-1:0] o_rnd
);

  logic [axil_slave_pkg::PRNG_W-1:0] state;
  logic [axil_slave_pkg::PRNG_W-1:0] state_nxt;
  logic                              rst_q;
  logic                              seed_now;

  // xorshift64, shifts 13/7/17
  always_comb begin
    state_nxt = state ^ (state << 13);
    state_nxt = state_nxt ^ (state_nxt >> 7);
    state_nxt = state_nxt ^ (state_nxt << 17);
  end

  always_ff @(posedge i_clk) begin
    rst_q <= i_rst;
  end

  assign seed_now = rst_q && !i_rst; // first cycle out of reset

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= '0;
    end else if (seed_now) begin
      state <= axil_slave_pkg::PRNG_SEED;
    end else begin
      state <= state_nxt;
    end
  end

  assign o_rnd = state;

endmodule

`default_nettype wire

//--- hw/payload_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module payload_fifo #(
  parameter type T          = logic,
  parameter int  FIFO_DEPTH = 4
) (
  input logic   i_clk,
  input logic   i_rst,
  fifo_if.queue q
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  T                 mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // wraps at FIFO_DEPTH, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_push = q.push && !q.full;  // push on full is dropped
  assign do_pop  = q.pop && !q.empty;

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= q.wdata;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // head shown without a register stage
  assign q.rdata = mem[rd_ptr];
  assign q.empty = (count == '0);
  assign q.full  = (count == CNT_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

//--- hw/slave_mem.sv
`timescale 1ns/1ps
`default_nettype none

module slave_mem #(
  parameter int                N_MEM_WORD = 16,
  parameter int                ADDR_W     = 16,
  parameter logic [ADDR_W-1:0] ADDR_BASE  = 16'h4000,
  parameter int                DATA_BYTEW = 4
) (
  input  logic                              i_clk,
  input  logic                              i_wr_en,
  input  logic [ADDR_W-1:0]                 i_wr_addr,
  input  logic [DATA_BYTEW*8-1:0]           i_wr_data,
  input  logic [DATA_BYTEW-1:0]             i_wr_strb,
  input  logic                              i_bresp_err,
  output axil_slave_pkg::axi_resp_e         o_bresp,
  input  logic [ADDR_W-1:0]                 i_rd_addr,
  input  logic                              i_rresp_err,
  input  logic                              i_corrupt,
  input  logic [axil_slave_pkg::PROB_W-1:0] i_corrupt_bit,
  output logic [DATA_BYTEW*8-1:0]           o_rd_data,
  output axil_slave_pkg::axi_resp_e         o_rresp
);

  localparam int DATA_W   = DATA_BYTEW * 8;
  localparam int OFFSET_W = $clog2(N_MEM_WORD);
  localparam int OFFSET_L = $clog2(DATA_BYTEW);  // byte lanes
  localparam int TAG_L    = OFFSET_W + OFFSET_L; // lowest window bit
  localparam int BIT_W    = $clog2(DATA_W);

  logic [DATA_W-1:0]   mem [N_MEM_WORD] = '{default: '0};
  logic [OFFSET_W-1:0] wr_off;
  logic [OFFSET_W-1:0] rd_off;
  logic                wr_in;
  logic                rd_in;
  logic [DATA_W-1:0]   rd_word;

  function automatic logic in_window(input logic [ADDR_W-1:0] addr);
    logic [OFFSET_W-1:0] off;
    off = addr[TAG_L-1:OFFSET_L];
    return (addr[ADDR_W-1:TAG_L] == ADDR_BASE[ADDR_W-1:TAG_L]) &&
           (int'(off) < N_MEM_WORD);
  endfunction

  // decode error wins over the random error
  function automatic axil_slave_pkg::axi_resp_e pick_resp(input logic in_range,
                                                          input logic err);
    if (!in_range) return axil_slave_pkg::RESP_DECERR;
    if (err) return axil_slave_pkg::RESP_SLVERR;
    return axil_slave_pkg::RESP_OKAY;
  endfunction

  assign wr_off = i_wr_addr[TAG_L-1:OFFSET_L];
  assign rd_off = i_rd_addr[TAG_L-1:OFFSET_L];
  assign wr_in  = in_window(i_wr_addr);
  assign rd_in  = in_window(i_rd_addr);

  always_ff @(posedge i_clk) begin
    if (i_wr_en && wr_in) begin
      for (int b = 0; b < DATA_BYTEW; b++) begin
        if (i_wr_strb[b]) begin
          mem[wr_off][b*8 +: 8] <= i_wr_data[b*8 +: 8];
        end
      end
    end
  end

  assign rd_word   = rd_in ? mem[rd_off] : '0; // zero data on decode error
  // flip one bit picked by the random byte
  assign o_rd_data = rd_word ^ (DATA_W'(i_corrupt) << i_corrupt_bit[BIT_W-1:0]);

  assign o_bresp = pick_resp(wr_in, i_bresp_err);
  assign o_rresp = pick_resp(rd_in, i_rresp_err);

endmodule

`default_nettype wire

//--- hw/resp_hold_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module resp_hold_fsm (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_not_empty,  // head entry waiting
  input  logic i_stall,
  input  logic i_ready,
  output logic o_valid,
  output logic o_stall
);

  typedef enum logic [1:0] {
    IDLE,   // queue was empty
    OFFER,  // head present, not yet seen by the master
    HOLD    // head offered, valid kept until ready
  } state_e;

  state_e state;
  state_e state_nxt;

  // once offered, the stall no longer applies
  assign o_valid = i_not_empty && (!i_stall || state == HOLD);
  assign o_stall = i_not_empty && i_stall && state != HOLD;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE, OFFER: begin
        if (!i_not_empty) begin
          state_nxt = IDLE;
        end else if (o_valid && !i_ready) begin
          state_nxt = HOLD;
        end else begin
          state_nxt = OFFER; // stalled, or taken and next head is new
        end
      end
      HOLD: begin
        if (i_ready) begin
          state_nxt = OFFER;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

`default_nettype wire

//--- hw/idle_timer.sv
`timescale 1ns/1ps
`default_nettype none

module idle_timer #(
  parameter int IDLE_TIMEOUT = 3
) (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_busy,
  output logic o_idle
);

  localparam int CNT_W = $clog2(IDLE_TIMEOUT + 1);

  logic [CNT_W-1:0] count;

  // reload while busy, then count down to zero and stay there
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      count <= '0;
    end else if (i_busy) begin
      count <= CNT_W'(IDLE_TIMEOUT);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign o_idle = !i_busy && (count == '0);

endmodule

`default_nettype wire

//--- hw/axil_random_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axil_random_slave #(
  parameter int                N_MEM_WORD   = 16,
  parameter int                ADDR_W       = 16,
  parameter logic [ADDR_W-1:0] ADDR_BASE    = 16'h4000,
  parameter int                DATA_BYTEW   = 4,
  parameter int                ID_W         = 4,
  parameter int                FIFO_DEPTH   = 4,
  parameter int                IDLE_TIMEOUT = 3
) (
  input  logic                              i_clk,
  input  logic                              i_rst,

  input  logic [ID_W-1:0]                   i_axi_awid,
  input  logic [ADDR_W-1:0]                 i_axi_awaddr,
  input  logic                              i_axi_awvalid,
  output logic                              o_axi_awready,

  input  logic [DATA_BYTEW*8-1:0]           i_axi_wdata,
  input  logic [DATA_BYTEW-1:0]             i_axi_wstrb,
  input  logic                              i_axi_wvalid,
  output logic                              o_axi_wready,

  output logic [ID_W-1:0]                   o_axi_bid,
  output logic [1:0]                        o_axi_bresp,
  output logic                              o_axi_bvalid,
  input  logic                              i_axi_bready,

  input  logic [ID_W-1:0]                   i_axi_arid,
  input  logic [ADDR_W-1:0]                 i_axi_araddr,
  input  logic                              i_axi_arvalid,
  output logic                              o_axi_arready,

  output logic [ID_W-1:0]                   o_axi_rid,
  output logic [DATA_BYTEW*8-1:0]           o_axi_rdata,
  output logic [1:0]                        o_axi_rresp,
  output logic                              o_axi_rvalid,
  input  logic                              i_axi_rready,

  // misbehaviour odds, compared against a fresh random byte each cycle
  input  logic [axil_slave_pkg::PROB_W-1:0] i_pr_aw_stall,
  input  logic [axil_slave_pkg::PROB_W-1:0] i_pr_w_stall,
  input  logic [axil_slave_pkg::PROB_W-1:0] i_pr_b_stall,
  input  logic [axil_slave_pkg::PROB_W-1:0] i_pr_ar_stall,
  input  logic [axil_slave_pkg::PROB_W-1:0] i_pr_r_stall,
  input  logic [axil_slave_pkg::PROB_W-1:0] i_pr_bresp_notokay,
  input  logic [axil_slave_pkg::PROB_W-1:0] i_pr_rresp_notokay,
  input  logic [axil_slave_pkg::PROB_W-1:0] i_pr_rddata_corrupt,

  output logic                              o_busy,
  output logic                              o_idle,
  output logic                              o_stall
);

  localparam int PW = axil_slave_pkg::PROB_W;

  typedef struct packed {
    logic [DATA_BYTEW*8-1:0] data;
    logic [DATA_BYTEW-1:0]   strb;
  } w_beat_t;

  typedef struct packed {
    logic [ID_W-1:0]           id;
    axil_slave_pkg::axi_resp_e resp;
  } b_beat_t;

  typedef struct packed {
    logic [ID_W-1:0]           id;
    axil_slave_pkg::axi_resp_e resp;
    logic [DATA_BYTEW*8-1:0]   data;
  } r_beat_t;

  logic [axil_slave_pkg::PRNG_W-1:0] prng_rnd;
  logic [7:0][PW-1:0]                rnd;       // one byte per control
  logic                              do_aw_stall;
  logic                              do_w_stall;
  logic                              do_b_stall;
  logic                              do_ar_stall;
  logic                              do_r_stall;
  logic                              do_bresp_err;
  logic                              do_rresp_err;
  logic                              do_corrupt;
  logic                              aw_hs;
  logic                              ar_hs;
  logic                              b_stall;
  logic                              r_stall;
  axil_slave_pkg::axi_resp_e         bresp;
  axil_slave_pkg::axi_resp_e         rresp;
  logic [DATA_BYTEW*8-1:0]           rd_data;

  fifo_if #(.T(w_beat_t)) w_q ();
  fifo_if #(.T(b_beat_t)) b_q ();
  fifo_if #(.T(r_beat_t)) r_q ();

  prng_xorshift u_prng (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .o_rnd (prng_rnd)
  );

  assign rnd = prng_rnd;

  // strictly greater, so 0 never misbehaves
  assign do_aw_stall  = i_pr_aw_stall       > rnd[0];
  assign do_w_stall   = i_pr_w_stall        > rnd[1];
  assign do_b_stall   = i_pr_b_stall        > rnd[2];
  assign do_ar_stall  = i_pr_ar_stall       > rnd[3];
  assign do_r_stall   = i_pr_r_stall        > rnd[4];
  assign do_bresp_err = i_pr_bresp_notokay  > rnd[5];
  assign do_rresp_err = i_pr_rresp_notokay  > rnd[6];
  assign do_corrupt   = i_pr_rddata_corrupt > rnd[7];

  // AW waits for its own W beat so each write uses fresh data
  assign o_axi_awready = !do_aw_stall && !b_q.full && !w_q.empty;
  assign o_axi_wready  = !do_w_stall && !w_q.full;
  assign o_axi_arready = !do_ar_stall && !r_q.full;

  assign aw_hs = i_axi_awvalid && o_axi_awready;
  assign ar_hs = i_axi_arvalid && o_axi_arready;

  assign w_q.push  = i_axi_wvalid && o_axi_wready;
  assign w_q.wdata = '{data: i_axi_wdata, strb: i_axi_wstrb};
  assign w_q.pop   = aw_hs;

  assign b_q.push  = aw_hs;
  assign b_q.wdata = '{id: i_axi_awid, resp: bresp};
  assign b_q.pop   = o_axi_bvalid && i_axi_bready;

  assign r_q.push  = ar_hs; // word as it stands before this edge
  assign r_q.wdata = '{id: i_axi_arid, resp: rresp, data: rd_data};
  assign r_q.pop   = o_axi_rvalid && i_axi_rready;

  payload_fifo #(.T(w_beat_t), .FIFO_DEPTH(FIFO_DEPTH)) u_wfifo (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .q     (w_q)
  );

  payload_fifo #(.T(b_beat_t), .FIFO_DEPTH(FIFO_DEPTH)) u_bfifo (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .q     (b_q)
  );

  payload_fifo #(.T(r_beat_t), .FIFO_DEPTH(FIFO_DEPTH)) u_rfifo (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .q     (r_q)
  );

  slave_mem #(
    .N_MEM_WORD (N_MEM_WORD),
    .ADDR_W     (ADDR_W),
    .ADDR_BASE  (ADDR_BASE),
    .DATA_BYTEW (DATA_BYTEW)
  ) u_mem (
    .i_clk         (i_clk),
    .i_wr_en       (aw_hs),
    .i_wr_addr     (i_axi_awaddr),
    .i_wr_data     (w_q.rdata.data),
    .i_wr_strb     (w_q.rdata.strb),
    .i_bresp_err   (do_bresp_err),
    .o_bresp       (bresp),
    .i_rd_addr     (i_axi_araddr),
    .i_rresp_err   (do_rresp_err),
    .i_corrupt     (do_corrupt),
    .i_corrupt_bit (rnd[7]),
    .o_rd_data     (rd_data),
    .o_rresp       (rresp)
  );

  resp_hold_fsm u_bhold (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_not_empty (!b_q.empty),
    .i_stall     (do_b_stall),
    .i_ready     (i_axi_bready),
    .o_valid     (o_axi_bvalid),
    .o_stall     (b_stall)
  );

  resp_hold_fsm u_rhold (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_not_empty (!r_q.empty),
    .i_stall     (do_r_stall),
    .i_ready     (i_axi_rready),
    .o_valid     (o_axi_rvalid),
    .o_stall     (r_stall)
  );

  assign o_axi_bid   = b_q.rdata.id;
  assign o_axi_bresp = b_q.rdata.resp;
  assign o_axi_rid   = r_q.rdata.id;
  assign o_axi_rresp = r_q.rdata.resp;
  assign o_axi_rdata = r_q.rdata.data;

  assign o_busy  = !b_q.empty || !r_q.empty; // responses still owed
  assign o_stall = b_stall || r_stall;

  idle_timer #(.IDLE_TIMEOUT(IDLE_TIMEOUT)) u_idle (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_busy (o_busy),
    .o_idle (o_idle)
  );

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 8
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) o_clk = ~o_clk; // half period per phase
    end
  end

endmodule

`default_nettype wire

//--- tb/axil_random_slave_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axil_random_slave_tb;

  localparam int                N_MEM_WORD   = 16;
  localparam int                ADDR_W       = 16;
  localparam logic [ADDR_W-1:0] ADDR_BASE    = 16'h4000;
  localparam int                DATA_BYTEW   = 4;
  localparam int                DATA_W       = DATA_BYTEW * 8;
  localparam int                ID_W         = 4;
  localparam int                FIFO_DEPTH   = 4;
  localparam int                IDLE_TIMEOUT = 3;
  localparam int                PW           = axil_slave_pkg::PROB_W;

  // writes per test, each paired with a read
  localparam int N_T2       = 24;
  localparam int N_T3       = 8;
  localparam int N_T4       = 40;
  localparam int N_T5       = 16;
  localparam int N_T6       = 4;
  localparam int N_TXN      = 2 * (N_T2 + N_T3 + N_T4 + N_T5 + N_T6) + N_MEM_WORD;
  localparam int MAX_CYCLES = N_TXN * 64 + 200;

  typedef struct packed {
    logic [ID_W-1:0]       id;
    logic [ADDR_W-1:0]     addr;
    logic [DATA_W-1:0]     data;
    logic [DATA_BYTEW-1:0] strb;
  } req_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [1:0]        resp;
    logic [DATA_W-1:0] data;
    logic              slv_ok;   // SLVERR accepted in place of OKAY
    logic              chk_data;
  } exp_t;

  logic                  clk;
  logic                  rst;
  logic [ID_W-1:0]       awid;
  logic [ADDR_W-1:0]     awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [DATA_W-1:0]     wdata;
  logic [DATA_BYTEW-1:0] wstrb;
  logic                  wvalid;
  logic                  wready;
  logic [ID_W-1:0]       bid;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic [ID_W-1:0]       arid;
  logic [ADDR_W-1:0]     araddr;
  logic                  arvalid;
  logic                  arready;
  logic [ID_W-1:0]       rid;
  logic [DATA_W-1:0]     rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;
  logic [PW-1:0]         pr_stall;
  logic [PW-1:0]         pr_err;
  logic [PW-1:0]         pr_corrupt;
  logic                  busy;
  logic                  idle;
  logic                  stall;

  integer            seed = 68162;
  int                cycles = 0;
  int                n_tests = 0;
  int                n_checks = 0;
  int                n_errors = 0;
  int                test_start_errors = 0;
  int                ready_pct = 80;
  int                stall_seen = 0;
  int                slverr_seen = 0;
  bit                err_mode = 0;
  bit                corrupt_mode = 0;
  bit                b_held = 0;
  bit                r_held = 0;
  exp_t              b_seen;
  exp_t              r_seen;
  logic [DATA_W-1:0] model_mem [int];
  logic [ADDR_W-1:0] addr_list [$];
  req_t              aw_pend [$];
  req_t              w_pend [$];
  req_t              ar_pend [$];
  exp_t              exp_b [$];
  exp_t              exp_r [$];

  tb_clock_gen #(.PERIOD_NS(8)) u_clk (.o_clk(clk));

  axil_random_slave #(
    .N_MEM_WORD   (N_MEM_WORD),
    .ADDR_W       (ADDR_W),
    .ADDR_BASE    (ADDR_BASE),
    .DATA_BYTEW   (DATA_BYTEW),
    .ID_W         (ID_W),
    .FIFO_DEPTH   (FIFO_DEPTH),
    .IDLE_TIMEOUT (IDLE_TIMEOUT)
  ) dut0 (
    .i_clk               (clk),
    .i_rst               (rst),
    .i_axi_awid          (awid),
    .i_axi_awaddr        (awaddr),
    .i_axi_awvalid       (awvalid),
    .o_axi_awready       (awready),
    .i_axi_wdata         (wdata),
    .i_axi_wstrb         (wstrb),
    .i_axi_wvalid        (wvalid),
    .o_axi_wready        (wready),
    .o_axi_bid           (bid),
    .o_axi_bresp         (bresp),
    .o_axi_bvalid        (bvalid),
    .i_axi_bready        (bready),
    .i_axi_arid          (arid),
    .i_axi_araddr        (araddr),
    .i_axi_arvalid       (arvalid),
    .o_axi_arready       (arready),
    .o_axi_rid           (rid),
    .o_axi_rdata         (rdata),
    .o_axi_rresp         (rresp),
    .o_axi_rvalid        (rvalid),
    .i_axi_rready        (rready),
    .i_pr_aw_stall       (pr_stall),
    .i_pr_w_stall        (pr_stall),
    .i_pr_b_stall        (pr_stall),
    .i_pr_ar_stall       (pr_stall),
    .i_pr_r_stall        (pr_stall),
    .i_pr_bresp_notokay  (pr_err),
    .i_pr_rresp_notokay  (pr_err),
    .i_pr_rddata_corrupt (pr_corrupt),
    .o_busy              (busy),
    .o_idle              (idle),
    .o_stall             (stall)
  );

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: traffic did not finish within %0d cycles", MAX_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
    n_checks++;
    if (exp !== got) begin
      $display("Fail %s exp 0x%0h got 0x%0h", name, exp, got);
      n_errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error: %s", msg);
    n_errors++;
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    $display("test %0d %s: %s, %0d errors", n_tests, name,
             (n_errors == test_start_errors) ? "ok" : "failed", n_errors - test_start_errors);
    test_start_errors = n_errors;
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic in_window(input logic [ADDR_W-1:0] addr);
    return (addr >= ADDR_BASE) && (addr < ADDR_BASE + N_MEM_WORD * DATA_BYTEW);
  endfunction

  function automatic int word_of(input logic [ADDR_W-1:0] addr);
    return int'(addr - ADDR_BASE) / DATA_BYTEW;
  endfunction

  function automatic logic [ADDR_W-1:0] rand_in_addr();
    return ADDR_BASE + ADDR_W'((rand32() % N_MEM_WORD) * DATA_BYTEW);
  endfunction

  function automatic logic [ADDR_W-1:0] rand_out_addr();
    logic [31:0] r;
    r = rand32();
    if (r[31]) begin
      return {1'b1, r[14:2], 2'b00}; // above the window
    end
    return {2'b00, r[13:2], 2'b00};
  endfunction

  function automatic int count_ones(input logic [DATA_W-1:0] v);
    int n;
    n = 0;
    for (int i = 0; i < DATA_W; i++) begin
      n += v[i];
    end
    return n;
  endfunction

  task automatic model_write(input req_t r);
    logic [DATA_W-1:0] word;
    word = model_mem[word_of(r.addr)];
    for (int b = 0; b < DATA_BYTEW; b++) begin
      if (r.strb[b]) begin
        word[b*8 +: 8] = r.data[b*8 +: 8];
      end
    end
    model_mem[word_of(r.addr)] = word;
  endtask

  // expected response, read data as the model stands now
  function automatic exp_t expect_for(input req_t r, input logic is_read);
    exp_t e;
    logic inr;
    inr        = in_window(r.addr);
    e.id       = r.id;
    e.resp     = inr ? axil_slave_pkg::RESP_OKAY : axil_slave_pkg::RESP_DECERR;
    e.slv_ok   = inr && err_mode;
    e.chk_data = is_read && inr;
    e.data     = e.chk_data ? model_mem[word_of(r.addr)] : '0;
    return e;
  endfunction

  task automatic queue_write(input logic [ADDR_W-1:0] addr);
    req_t r;
    r.id   = ID_W'(rand32());
    r.addr = addr;
    r.data = rand32();
    r.strb = DATA_BYTEW'(rand32());
    aw_pend.push_back(r);
    w_pend.push_back(r);
  endtask

  task automatic queue_read(input logic [ADDR_W-1:0] addr);
    req_t r;
    r      = '0;
    r.id   = ID_W'(rand32());
    r.addr = addr;
    ar_pend.push_back(r);
  endtask

  task automatic check_resp(input string name, input exp_t e, input logic [1:0] got);
    if (e.slv_ok && got == axil_slave_pkg::RESP_SLVERR) begin
      slverr_seen++;
    end else begin
      check_val(name, e.resp, got);
    end
  endtask

  task automatic drive_inputs();
    awvalid = aw_pend.size() > 0;
    if (awvalid) begin
      awid   = aw_pend[0].id;
      awaddr = aw_pend[0].addr;
    end
    wvalid = w_pend.size() > 0;
    if (wvalid) begin
      wdata = w_pend[0].data;
      wstrb = w_pend[0].strb;
    end
    arvalid = ar_pend.size() > 0;
    if (arvalid) begin
      arid   = ar_pend[0].id;
      araddr = ar_pend[0].addr;
    end
    bready = (rand32() % 100) < ready_pct;
    rready = (rand32() % 100) < ready_pct;
  endtask

  // readies, valids and status from the queue fill seen so far
  task automatic check_flow();
    int w_cnt;
    w_cnt = aw_pend.size() - w_pend.size(); // W beats taken, AW still owed
    check_val("o_busy", exp_b.size() > 0 || exp_r.size() > 0, busy);
    if (pr_stall == 0) begin
      check_val("o_axi_awready", exp_b.size() < FIFO_DEPTH && w_cnt > 0, awready);
      check_val("o_axi_wready", w_cnt < FIFO_DEPTH, wready);
      check_val("o_axi_arready", exp_r.size() < FIFO_DEPTH, arready);
      check_val("o_axi_bvalid", exp_b.size() > 0, bvalid);
      check_val("o_axi_rvalid", exp_r.size() > 0, rvalid);
      check_val("o_stall", 0, stall);
    end
  endtask

  task automatic check_b();
    exp_t e;
    if (b_held) begin
      if (!bvalid) report_error("bvalid dropped before its handshake");
      check_val("o_axi_bid", b_seen.id, bid);
      check_val("o_axi_bresp", b_seen.resp, bresp);
    end
    if (bvalid && bready) begin
      if (exp_b.size() == 0) begin
        report_error("write response with no write outstanding");
      end else begin
        e = exp_b.pop_front();
        check_val("o_axi_bid", e.id, bid);
        check_resp("o_axi_bresp", e, bresp);
      end
    end
    b_held      = bvalid && !bready;
    b_seen.id   = bid;
    b_seen.resp = bresp;
  endtask

  task automatic check_r();
    exp_t e;
    if (r_held) begin
      if (!rvalid) report_error("rvalid dropped before its handshake");
      check_val("o_axi_rid", r_seen.id, rid);
      check_val("o_axi_rresp", r_seen.resp, rresp);
      check_val("o_axi_rdata", r_seen.data, rdata);
    end
    if (rvalid && rready) begin
      if (exp_r.size() == 0) begin
        report_error("read response with no read outstanding");
      end else begin
        e = exp_r.pop_front();
        check_val("o_axi_rid", e.id, rid);
        check_resp("o_axi_rresp", e, rresp);
        // one flipped bit allowed while corruption is on
        if (e.chk_data && !(corrupt_mode && count_ones(e.data ^ rdata) <= 1)) begin
          check_val("o_axi_rdata", e.data, rdata);
        end
      end
    end
    r_held      = rvalid && !rready;
    r_seen.id   = rid;
    r_seen.resp = rresp;
    r_seen.data = rdata;
  endtask

  // at the falling edge, handshakes that the next rising edge will take
  task automatic observe();
    req_t r;
    check_flow();
    if (arvalid && arready) begin
      r = ar_pend.pop_front();
      exp_r.push_back(expect_for(r, 1'b1)); // before any write of this edge
    end
    if (awvalid && awready) begin
      r = aw_pend.pop_front();
      exp_b.push_back(expect_for(r, 1'b0));
      if (in_window(r.addr)) model_write(r);
    end
    if (wvalid && wready) void'(w_pend.pop_front());
    if (stall) stall_seen++;
    check_b();
    check_r();
  endtask

  task automatic run_traffic();
    while (aw_pend.size() > 0 || w_pend.size() > 0 || ar_pend.size() > 0 ||
           exp_b.size() > 0 || exp_r.size() > 0) begin
      @(posedge clk);
      #1;
      drive_inputs();
      @(negedge clk);
      observe();
    end
    @(posedge clk);
    #1;
    drive_inputs(); // nothing pending, valids go low
    b_held = 0;
    r_held = 0;
  endtask

  // reads of addr_list in back-to-back groups of 1 to 4
  task automatic read_back_bursts();
    int i;
    int n;
    i = 0;
    while (i < addr_list.size()) begin
      n = 1 + int'(rand32() % 4);
      for (int k = 0; k < n && i < addr_list.size(); k++) begin
        queue_read(addr_list[i]);
        i++;
      end
      run_traffic();
    end
  endtask

  initial begin
    int idle_wait;
    logic [ADDR_W-1:0] a;
    rst        = 1'b1;
    awid       = '0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    arid       = '0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    pr_stall   = '0;
    pr_err     = '0;
    pr_corrupt = '0;
    for (int i = 0; i < N_MEM_WORD; i++) begin
      model_mem[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    @(negedge clk);
    check_val("o_axi_bvalid", 0, bvalid);
    check_val("o_axi_rvalid", 0, rvalid);
    check_val("o_busy", 0, busy);
    check_val("o_stall", 0, stall);
    check_val("o_idle", 1, idle);
    finish_test("after reset");

    repeat (N_T2) begin
      a = rand_in_addr();
      addr_list.push_back(a);
      queue_write(a);
    end
    run_traffic();
    read_back_bursts();
    finish_test("all probabilities 0");

    repeat (N_T3) begin
      a = rand_out_addr();
      queue_write(a);
      queue_read(a);
    end
    run_traffic();
    addr_list.delete();
    for (int w = 0; w < N_MEM_WORD; w++) begin
      addr_list.push_back(ADDR_BASE + ADDR_W'(w * DATA_BYTEW));
    end
    read_back_bursts(); // whole window, nothing may have changed
    finish_test("out-of-range addresses");

    pr_stall   = 8'd200;
    ready_pct  = 50;
    stall_seen = 0;
    repeat (N_T4) begin
      queue_write(rand_in_addr());
      queue_read(rand_in_addr());
    end
    run_traffic();
    if (stall_seen == 0) report_error("o_stall never seen with stall probability 200");
    pr_stall  = '0;
    ready_pct = 80;
    finish_test("stalls and random ready");

    pr_err       = 8'd255;
    pr_corrupt   = 8'd255;
    err_mode     = 1;
    corrupt_mode = 1;
    slverr_seen  = 0;
    addr_list.delete();
    repeat (N_T5) begin
      a = rand_in_addr();
      addr_list.push_back(a);
      queue_write(a);
    end
    run_traffic();
    read_back_bursts();
    if (slverr_seen == 0) report_error("no SLVERR seen with error probability 255");
    pr_err       = '0;
    pr_corrupt   = '0;
    err_mode     = 0;
    corrupt_mode = 0;
    finish_test("errors and corruption");

    // exact reads here also show that the writes above committed
    repeat (N_T6) begin
      queue_write(rand_in_addr());
      queue_read(rand_in_addr());
    end
    run_traffic();
    @(negedge clk);
    check_val("o_busy", 0, busy);
    idle_wait = 0;
    while (!idle && idle_wait < 4 * IDLE_TIMEOUT + 4) begin
      @(negedge clk);
      idle_wait++;
    end
    check_val("o_idle delay", IDLE_TIMEOUT, idle_wait);
    repeat (10) begin
      @(negedge clk);
      check_val("o_idle", 1, idle);
    end
    finish_test("idle");

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
hw/axil_slave_pkg.sv
hw/fifo_if.sv
hw/prng_xorshift.sv
hw/payload_fifo.sv
hw/slave_mem.sv
hw/resp_hold_fsm.sv
hw/idle_timer.sv
hw/axil_random_slave.sv
tb/tb_clock_gen.sv
tb/axil_random_slave_tb.sv
